//--- verif/w5500_vectors.txt
# columns, all hex: cmd sock rw addr bytes seed (rw 1 writes, 0 reads)
# register lines give the expected W5500 offset and fixed size; buffer lines give i_addr
01 5 1 0001 0004 c0
03 0 1 0009 0006 10
14 2 1 0004 0002 50
02 0 1 0005 0004 fe
05 0 0 002e 0001 00
13 1 0 0003 0001 00
17 3 1 0020 0002 77
19 4 0 0026 0002 00
20 1 1 0100 0001 3c
20 5 1 07f0 0028 80
20 2 0 0200 0008 00
3f 0 1 1234 0004 00
10 7 1 0000 0001 21
04 6 0 000f 0004 00
1b 0 1 002f 0001 0a
18 3 0 0024 0002 00
ee 3 0 0000 0000 00

//--- w5500_spi_top.f
hw/w5500_pkg.sv
hw/w5500_tx_buf.sv
hw/spi_master.sv
hw/w5500_cmd_seq.sv
hw/w5500_spi_top.sv
verif/w5500_slave_model.sv
verif/w5500_spi_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module w5500_spi_tb \
	-f w5500_spi_top.f \
	-o w5500_sim

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/w5500_sim

//--- verif/w5500_spi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module w5500_spi_tb;
	import w5500_pkg::*;

	localparam logic [CLK_DIV_W-1:0] CLK_DIV = 16'd2;

	logic                 clk;
	logic                 rst_n;
	logic                 spi_cs;
	logic                 spi_dclk;
	logic                 spi_mosi;
	logic                 spi_miso;
	logic [CLK_DIV_W-1:0] clk_div;
	logic [CMD_W-1:0]     cmd;
	logic                 cmd_valid;
	logic                 cmd_ack;
	logic [2:0]           sock_num;
	logic                 rw;
	logic [15:0]          addr;
	logic [15:0]          byte_size;
	logic                 buf_wr_en;
	logic [BUF_AW-1:0]    buf_wr_addr;
	logic [7:0]           buf_wr_data;
	logic [7:0]           rd_data;
	logic                 rd_valid;

	// one entry per vector line
	logic [7:0]  v_cmd[$];
	logic [2:0]  v_sock[$];
	logic        v_rw[$];
	logic [15:0] v_addr[$];
	logic [15:0] v_len[$];
	logic [7:0]  v_seed[$];

	logic [7:0]  rd_q[$]; // every read byte the DUT returned
	int          ack_count = 0;
	int unsigned cycles = 0;
	int unsigned cycle_limit = 1000;
	integer      seed = 32'h2c8c1855;
	int          vi;

	w5500_spi_top uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.o_spi_cs      (spi_cs),
		.o_spi_dclk    (spi_dclk),
		.o_spi_mosi    (spi_mosi),
		.i_spi_miso    (spi_miso),
		.i_clk_div     (clk_div),
		.i_cmd         (cmd),
		.i_cmd_valid   (cmd_valid),
		.o_cmd_ack     (cmd_ack),
		.i_sock_num    (sock_num),
		.i_rw          (rw),
		.i_addr        (addr),
		.i_byte_size   (byte_size),
		.i_buf_wr_en   (buf_wr_en),
		.i_buf_wr_addr (buf_wr_addr),
		.i_buf_wr_data (buf_wr_data),
		.o_rd_data     (rd_data),
		.o_rd_valid    (rd_valid)
	);

	w5500_slave_model u_slave (
		.i_cs   (spi_cs),
		.i_dclk (spi_dclk),
		.i_mosi (spi_mosi),
		.o_miso (spi_miso)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// monitors and watchdog
	//////////////////////////////
	always @(negedge clk) begin
		if (rd_valid)
			rd_q.push_back(rd_data);
		if (cmd_ack)
			ack_count = ack_count + 1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
			stop_with_failure($sformatf("Timeout after %0d clock cycles", cycles));
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
	                           input logic [31:0] expected);
		if (actual !== expected)
			stop_with_failure($sformatf("Error at %0d ns: %s: got 0x%0h, expected 0x%0h",
			                            $time, what, actual, expected));
	endtask

	function automatic bit is_known(input logic [7:0] c);
		case (c)
			CMD_GATEWAY, CMD_NETMASK, CMD_SMAC, CMD_SIP, CMD_PHY_STATE, CMD_RTR, CMD_RCR,
			CMD_SOCK_MODE, CMD_SOCK_CMD, CMD_SOCK_INT, CMD_SOCK_STATE, CMD_SOCK_SPORT,
			CMD_SOCK_RBUF_SIZE, CMD_SOCK_TBUF_SIZE, CMD_SOCK_TX_FSIZE, CMD_SOCK_TX_WPOINT,
			CMD_SOCK_RX_SIZE, CMD_SOCK_RX_RPOINT, CMD_SOCK_KEEPALIVE, CMD_SOCK_BUF:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// control byte is socket, block select, direction and two zero mode bits
	function automatic logic [7:0] expected_ctrl(input logic [7:0] c, input logic [2:0] s,
	                                             input logic dir);
		logic [2:0] sock;
		logic [1:0] bsb;
		logic       d;
		sock = s;
		bsb  = BSB_SOCK_REG;
		d    = dir;
		case (c)
			CMD_GATEWAY, CMD_NETMASK, CMD_SMAC, CMD_SIP, CMD_PHY_STATE, CMD_RTR, CMD_RCR: begin
				sock = 3'd0;
				bsb  = BSB_COMMON;
			end
			CMD_SOCK_TX_FSIZE, CMD_SOCK_RX_SIZE:
				d = RW_READ;
			CMD_SOCK_BUF:
				bsb = (dir == RW_WRITE) ? BSB_SOCK_TX : BSB_SOCK_RX;
			default:
				bsb = BSB_SOCK_REG;
		endcase
		return {sock, bsb, d, 2'b00};
	endfunction

	//////////////////////////////
	// vectors
	//////////////////////////////
	task automatic read_vectors();
		int         fd;
		int         n;
		string      line;
		logic [7:0] f_cmd;
		logic [7:0] f_sock;
		logic [7:0] f_rw;
		logic [15:0] f_addr;
		logic [15:0] f_len;
		logic [7:0] f_seed;
		fd = $fopen("verif/w5500_vectors.txt", "r");
		if (fd == 0)
			stop_with_failure("Could not open the vector file verif/w5500_vectors.txt");
		while (!$feof(fd)) begin
			line = "";
			n    = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h",
				            f_cmd, f_sock, f_rw, f_addr, f_len, f_seed);
				if (n != 6)
					stop_with_failure($sformatf("Vector line is malformed: %s", line));
				v_cmd.push_back(f_cmd);
				v_sock.push_back(f_sock[2:0]);
				v_rw.push_back(f_rw[0]);
				v_addr.push_back(f_addr);
				v_len.push_back(f_len);
				v_seed.push_back(f_seed);
			end
		end
		$fclose(fd);
		if (v_cmd.size() == 0)
			stop_with_failure("The vector file holds no vectors");
	endtask

	task automatic run_command(input int i);
		logic [7:0] ctrl;
		logic [7:0] exp_b;
		bit         known;
		bit         is_rd;
		int         nbytes;
		int         k;
		int         falls0;
		int         rises0;
		int         bytes0;
		int         dclk0;
		int         acks0;
		int         rd0;
		int         gap;
		known  = is_known(v_cmd[i]);
		ctrl   = expected_ctrl(v_cmd[i], v_sock[i], v_rw[i]);
		is_rd  = (ctrl[2] == RW_READ);
		nbytes = int'(v_len[i]);
		if (v_rw[i] == RW_WRITE) begin
			for (k = 0; k < nbytes; k++) begin
				buf_wr_en   = 1'b1;
				buf_wr_addr = k[BUF_AW-1:0];
				buf_wr_data = v_seed[i] + k[7:0];
				@(negedge clk);
			end
			buf_wr_en = 1'b0;
		end
		falls0 = u_slave.cs_falls;
		rises0 = u_slave.cs_rises;
		bytes0 = u_slave.bytes_seen;
		dclk0  = u_slave.dclk_rises;
		acks0  = ack_count;
		rd0    = rd_q.size();
		cmd       = v_cmd[i];
		sock_num  = v_sock[i];
		rw        = v_rw[i];
		// register commands take their address and size from the command code alone
		if (v_cmd[i] == CMD_SOCK_BUF) begin
			addr      = v_addr[i];
			byte_size = v_len[i];
		end else begin
			addr      = ~v_addr[i];
			byte_size = v_len[i] + 16'd3;
		end
		cmd_valid = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
		while (!cmd_ack)
			@(negedge clk);
		gap = 2 + ($random(seed) & 7);
		repeat (gap) @(negedge clk);
		check_value($sformatf("vector %0d ack count", i), ack_count - acks0, 1);
		check_value($sformatf("vector %0d chip select after ack", i), spi_cs, 1'b1);
		if (!known) begin
			check_value($sformatf("vector %0d cs falls", i), u_slave.cs_falls - falls0, 0);
			check_value($sformatf("vector %0d dclk edges", i), u_slave.dclk_rises - dclk0, 0);
			check_value($sformatf("vector %0d bytes", i), u_slave.bytes_seen - bytes0, 0);
			check_value($sformatf("vector %0d read bytes", i), rd_q.size() - rd0, 0);
		end else begin
			check_value($sformatf("vector %0d cs falls", i), u_slave.cs_falls - falls0, 1);
			check_value($sformatf("vector %0d cs rises", i), u_slave.cs_rises - rises0, 1);
			check_value($sformatf("vector %0d bytes", i), u_slave.bytes_seen - bytes0,
			            nbytes + HDR_BYTES);
			check_value($sformatf("vector %0d frame size", i), u_slave.frame_q.size(),
			            nbytes + HDR_BYTES);
			for (k = 0; k < nbytes + HDR_BYTES; k++) begin
				if (k == 0)
					exp_b = v_addr[i][15:8];
				else if (k == 1)
					exp_b = v_addr[i][7:0];
				else if (k == 2)
					exp_b = ctrl;
				else if (is_rd)
					exp_b = 8'h00; // reads clock out zeros
				else
					exp_b = v_seed[i] + 8'(k - 3);
				check_value($sformatf("vector %0d frame byte %0d", i, k),
				            u_slave.frame_q[k], exp_b);
			end
			check_value($sformatf("vector %0d read bytes", i), rd_q.size() - rd0,
			            is_rd ? nbytes : 0);
			for (k = 0; is_rd && k < nbytes; k++)
				check_value($sformatf("vector %0d read byte %0d", i, k), rd_q[rd0 + k],
				            (v_addr[i][7:0] + 8'(k)) ^ 8'hA5);
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		rst_n       = 1'b0;
		clk_div     = CLK_DIV;
		cmd         = '0;
		cmd_valid   = 1'b0;
		sock_num    = 3'd0;
		rw          = RW_READ;
		addr        = 16'h0000;
		byte_size   = 16'h0000;
		buf_wr_en   = 1'b0;
		buf_wr_addr = '0;
		buf_wr_data = 8'h00;
		read_vectors();
		cycle_limit = 0;
		for (vi = 0; vi < v_cmd.size(); vi++)
			cycle_limit = cycle_limit + (v_len[vi] + HDR_BYTES) * 32 * CLK_DIV + 200;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("chip select after reset", spi_cs, 1'b1);
		check_value("dclk after reset", spi_dclk, 1'b0);
		check_value("ack after reset", cmd_ack, 1'b0);
		check_value("read valid after reset", rd_valid, 1'b0);
		for (vi = 0; vi < v_cmd.size(); vi++)
			run_command(vi);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/w5500_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module w5500_slave_model (
	input  wire  i_cs,
	input  wire  i_dclk,
	input  wire  i_mosi,
	output logic o_miso
);
	logic [7:0] frame_q[$]; // header and data bytes of the latest frame
	logic [7:0] rx_sr = 8'h00;
	logic [7:0] tx_sr = 8'h00;
	logic       miso_q = 1'b0;
	int         bit_cnt = 0;
	int         frames_seen = 0;
	int         cs_falls = 0;
	int         cs_rises = 0;
	int         bytes_seen = 0; // all bytes over the whole run
	int         dclk_rises = 0;

	assign o_miso = miso_q;

	//////////////////////////////
	// chip select
	//////////////////////////////
	always @(negedge i_cs) begin
		cs_falls = cs_falls + 1;
	end

	always @(posedge i_cs) begin
		cs_rises = cs_rises + 1;
	end

	//////////////////////////////
	// mosi capture
	//////////////////////////////
	always @(posedge i_dclk) begin
		dclk_rises = dclk_rises + 1;
		if (!i_cs) begin
			if (frames_seen != cs_falls) begin
				frame_q.delete(); // first edge of a new frame
				frames_seen = cs_falls;
			end
			rx_sr   = {rx_sr[6:0], i_mosi};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 8) begin
				frame_q.push_back(rx_sr);
				bytes_seen = bytes_seen + 1;
				bit_cnt    = 0;
			end
		end
	end

	//////////////////////////////
	// miso drive
	//////////////////////////////
	// the next response byte is loaded on the falling edge that ends the byte before it
	always @(negedge i_dclk) begin
		if (bit_cnt != 0) begin
			miso_q = tx_sr[7];
			tx_sr  = {tx_sr[6:0], 1'b0};
		end else if (frame_q.size() >= 3) begin
			tx_sr  = (frame_q[1] + 8'(frame_q.size() - 3)) ^ 8'hA5; // data byte k
			miso_q = tx_sr[7];
			tx_sr  = {tx_sr[6:0], 1'b0};
		end else begin
			miso_q = 1'b0; // header bytes get zeros
			tx_sr  = 8'h00;
		end
	end

endmodule

`default_nettype wire

//--- hw/w5500_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

module w5500_spi_top (
	input  wire                             clk,
	input  wire                             rst_n,
	output logic                            o_spi_cs,
	output logic                            o_spi_dclk,
	output logic                            o_spi_mosi,
	input  wire                             i_spi_miso,
	input  wire [w5500_pkg::CLK_DIV_W-1:0]  i_clk_div,
	input  wire [w5500_pkg::CMD_W-1:0]      i_cmd,
	input  wire                             i_cmd_valid,
	output logic                            o_cmd_ack,
	input  wire [2:0]                       i_sock_num,
	input  wire                             i_rw,
	input  wire [15:0]                      i_addr,
	input  wire [15:0]                      i_byte_size,
	input  wire                             i_buf_wr_en,
	input  wire [w5500_pkg::BUF_AW-1:0]     i_buf_wr_addr,
	input  wire [7:0]                       i_buf_wr_data,
	output logic [7:0]                      o_rd_data,
	output logic                            o_rd_valid
);
	import w5500_pkg::*;

	logic [BUF_AW-1:0] buf_rd_addr;
	logic [7:0]        buf_rd_data;
	logic              cs_ctrl;
	logic              wr_req;
	logic              wr_ack;
	logic [7:0]        tx_byte;
	logic [7:0]        rx_byte;

	w5500_tx_buf u_tx_buf (
		.clk       (clk),
		.i_wr_en   (i_buf_wr_en),
		.i_wr_addr (i_buf_wr_addr),
		.i_wr_data (i_buf_wr_data),
		.i_rd_addr (buf_rd_addr),
		.o_rd_data (buf_rd_data)
	);

	w5500_cmd_seq u_cmd_seq (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_cmd         (i_cmd),
		.i_cmd_valid   (i_cmd_valid),
		.i_sock_num    (i_sock_num),
		.i_rw          (i_rw),
		.i_addr        (i_addr),
		.i_byte_size   (i_byte_size),
		.i_buf_rd_data (buf_rd_data),
		.i_wr_ack      (wr_ack),
		.i_rx_byte     (rx_byte),
		.o_cmd_ack     (o_cmd_ack),
		.o_buf_rd_addr (buf_rd_addr),
		.o_cs_ctrl     (cs_ctrl),
		.o_wr_req      (wr_req),
		.o_tx_byte     (tx_byte),
		.o_rd_data     (o_rd_data),
		.o_rd_valid    (o_rd_valid)
	);

	spi_master u_spi_master (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_cs_ctrl  (cs_ctrl),
		.i_clk_div  (i_clk_div),
		.i_wr_req   (wr_req),
		.i_tx_byte  (tx_byte),
		.i_spi_miso (i_spi_miso),
		.o_wr_ack   (wr_ack),
		.o_rx_byte  (rx_byte),
		.o_spi_cs   (o_spi_cs),
		.o_spi_dclk (o_spi_dclk),
		.o_spi_mosi (o_spi_mosi)
	);

endmodule

`default_nettype wire

//--- hw/w5500_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module w5500_cmd_seq (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire [w5500_pkg::CMD_W-1:0]    i_cmd,
	input  wire                           i_cmd_valid,
	input  wire [2:0]                     i_sock_num,
	input  wire                           i_rw,
	input  wire [15:0]                    i_addr,
	input  wire [15:0]                    i_byte_size,
	input  wire [7:0]                     i_buf_rd_data,
	input  wire                           i_wr_ack,
	input  wire [7:0]                     i_rx_byte,
	output logic                          o_cmd_ack,
	output logic [w5500_pkg::BUF_AW-1:0]  o_buf_rd_addr,
	output logic                          o_cs_ctrl,
	output logic                          o_wr_req,
	output logic [7:0]                    o_tx_byte,
	output logic [7:0]                    o_rd_data,
	output logic                          o_rd_valid
);
	import w5500_pkg::*;

	localparam logic [2:0] S_IDLE    = 3'd0;
	localparam logic [2:0] S_CS_LOW  = 3'd1;
	localparam logic [2:0] S_ADDR    = 3'd2;
	localparam logic [2:0] S_CTRL    = 3'd3;
	localparam logic [2:0] S_DATA    = 3'd4;
	localparam logic [2:0] S_CS_HIGH = 3'd5;

	logic [2:0]  state;
	logic        known_q;
	logic [15:0] cnt_q;
	logic [1:0]  gap_q;
	logic [15:0] addr_q;
	logic [7:0]  ctrl_q;
	logic [15:0] len_q;

	logic [15:0] dec_addr;
	logic [15:0] dec_len;
	logic [1:0]  dec_bsb;
	logic        dec_rw;
	logic        dec_common;
	logic        dec_known;

	logic        is_write;
	logic        last_data;
	logic        issue;
	logic        end_frame;
	logic [7:0]  next_byte;

	//////////////////////////////
	// command decode
	//////////////////////////////
	always_comb begin
		dec_addr  = i_addr;
		dec_known = 1'b1;
		case (i_cmd)
			CMD_GATEWAY:        dec_addr = REG_GAR0;
			CMD_NETMASK:        dec_addr = REG_SUBR0;
			CMD_SMAC:           dec_addr = REG_SHAR0;
			CMD_SIP:            dec_addr = REG_SIPR0;
			CMD_PHY_STATE:      dec_addr = REG_PHYCFGR;
			CMD_RTR:            dec_addr = REG_RTR0;
			CMD_RCR:            dec_addr = REG_RCR;
			CMD_SOCK_MODE:      dec_addr = SN_MR;
			CMD_SOCK_CMD:       dec_addr = SN_CR;
			CMD_SOCK_INT:       dec_addr = SN_IR;
			CMD_SOCK_STATE:     dec_addr = SN_SR;
			CMD_SOCK_SPORT:     dec_addr = SN_PORT0;
			CMD_SOCK_RBUF_SIZE: dec_addr = SN_RXBUF_SIZE;
			CMD_SOCK_TBUF_SIZE: dec_addr = SN_TXBUF_SIZE;
			CMD_SOCK_TX_FSIZE:  dec_addr = SN_TX_FSR0;
			CMD_SOCK_TX_WPOINT: dec_addr = SN_TX_WR0;
			CMD_SOCK_RX_SIZE:   dec_addr = SN_RX_RSR0;
			CMD_SOCK_RX_RPOINT: dec_addr = SN_RX_RD0;
			CMD_SOCK_KEEPALIVE: dec_addr = SN_KPALVTR;
			CMD_SOCK_BUF:       dec_addr = i_addr;
			default:            dec_known = 1'b0;
		endcase
	end

	always_comb begin
		case (i_cmd)
			CMD_SMAC:
				dec_len = 16'd6;
			CMD_GATEWAY, CMD_NETMASK, CMD_SIP:
				dec_len = 16'd4;
			CMD_SOCK_SPORT, CMD_SOCK_TX_FSIZE, CMD_SOCK_TX_WPOINT,
			CMD_SOCK_RX_SIZE, CMD_SOCK_RX_RPOINT, CMD_RTR:
				dec_len = 16'd2;
			CMD_SOCK_BUF:
				dec_len = i_byte_size;
			default:
				dec_len = 16'd1;
		endcase
	end

	always_comb begin
		dec_rw     = i_rw;
		dec_common = 1'b0;
		dec_bsb    = BSB_SOCK_REG;
		case (i_cmd)
			CMD_GATEWAY, CMD_NETMASK, CMD_SMAC, CMD_SIP,
			CMD_PHY_STATE, CMD_RTR, CMD_RCR: begin
				dec_common = 1'b1;
				dec_bsb    = BSB_COMMON;
			end
			CMD_SOCK_TX_FSIZE, CMD_SOCK_RX_SIZE:
				dec_rw = RW_READ; // these registers cannot be written
			CMD_SOCK_BUF:
				dec_bsb = (i_rw == RW_WRITE) ? BSB_SOCK_TX : BSB_SOCK_RX;
			default:
				dec_bsb = BSB_SOCK_REG;
		endcase
	end

	//////////////////////////////
	// byte issue
	//////////////////////////////
	assign is_write  = (ctrl_q[2] == RW_WRITE);
	assign last_data = (cnt_q == len_q - 16'd1);

	assign issue = (state == S_CS_LOW && known_q) ||
	               (state == S_ADDR && i_wr_ack) ||
	               (state == S_CTRL && i_wr_ack && len_q != 16'd0) ||
	               (state == S_DATA && gap_q == 2'd1);

	assign end_frame = i_wr_ack && ((state == S_CTRL && len_q == 16'd0) ||
	                                (state == S_DATA && last_data));

	always_comb begin
		case (state)
			S_CS_LOW: next_byte = addr_q[15:8];
			S_ADDR:   next_byte = (cnt_q == 16'd0) ? addr_q[7:0] : ctrl_q;
			default:  next_byte = is_write ? i_buf_rd_data : 8'h00; // reads clock out zeros
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_cmd_valid) begin
			addr_q <= dec_addr;
			len_q  <= dec_len;
			ctrl_q <= {(dec_common ? 3'd0 : i_sock_num), dec_bsb, dec_rw, 2'b00};
		end
		if (issue)
			o_tx_byte <= next_byte;
		if (state == S_DATA && i_wr_ack && !is_write)
			o_rd_data <= i_rx_byte;
	end

	//////////////////////////////
	// frame FSM
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= S_IDLE;
			known_q       <= 1'b0;
			cnt_q         <= 16'd0;
			gap_q         <= 2'd0;
			o_buf_rd_addr <= '0;
			o_cs_ctrl     <= 1'b1;
			o_wr_req      <= 1'b0;
			o_cmd_ack     <= 1'b0;
			o_rd_valid    <= 1'b0;
		end else begin
			o_wr_req   <= issue;
			o_cmd_ack  <= (state == S_CS_HIGH);
			o_rd_valid <= (state == S_DATA) && i_wr_ack && !is_write;
			if (end_frame)
				o_cs_ctrl <= 1'b1;
			case (state)
				S_IDLE: begin
					cnt_q         <= 16'd0;
					gap_q         <= 2'd0;
					o_buf_rd_addr <= '0; // first payload byte is read ahead
					if (i_cmd_valid) begin
						known_q <= dec_known;
						state   <= S_CS_LOW;
					end
				end
				S_CS_LOW: begin
					if (known_q) begin
						o_cs_ctrl <= 1'b0;
						state     <= S_ADDR;
					end else begin
						state <= S_CS_HIGH; // no frame, chip select stays high
					end
				end
				S_ADDR: begin
					if (i_wr_ack) begin
						if (cnt_q == 16'd0) begin
							cnt_q <= 16'd1;
						end else begin
							cnt_q <= 16'd0;
							state <= S_CTRL;
						end
					end
				end
				S_CTRL: begin
					if (i_wr_ack)
						state <= (len_q == 16'd0) ? S_CS_HIGH : S_DATA;
				end
				S_DATA: begin
					if (i_wr_ack) begin
						if (last_data) begin
							state <= S_CS_HIGH;
						end else begin
							cnt_q <= cnt_q + 16'd1;
							gap_q <= 2'd2; // buffer needs two cycles for the new address
							if (is_write)
								o_buf_rd_addr <= o_buf_rd_addr + 1'b1;
						end
					end else if (gap_q != 2'd0) begin
						gap_q <= gap_q - 2'd1;
					end
				end
				S_CS_HIGH: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             i_cs_ctrl,
	input  wire [w5500_pkg::CLK_DIV_W-1:0]  i_clk_div,
	input  wire                             i_wr_req,
	input  wire [7:0]                       i_tx_byte,
	input  wire                             i_spi_miso,
	output logic                            o_wr_ack,
	output logic [7:0]                      o_rx_byte,
	output logic                            o_spi_cs,
	output logic                            o_spi_dclk,
	output logic                            o_spi_mosi
);
	import w5500_pkg::*;

	logic                 busy;
	logic [CLK_DIV_W-1:0] div_cnt;
	logic [2:0]           bit_cnt;
	logic [7:0]           tx_shift;
	logic [7:0]           rx_shift;
	logic                 half_end;

	// a divider of zero runs like a divider of one
	assign half_end = busy && ((div_cnt == i_clk_div - 1'b1) || (i_clk_div == '0));

	// the byte ends on the eighth falling edge of dclk
	assign o_wr_ack = half_end && o_spi_dclk && (bit_cnt == 3'd7);

	assign o_spi_cs   = i_cs_ctrl; // the sequencer owns the frame
	assign o_spi_mosi = tx_shift[7];
	assign o_rx_byte  = rx_shift;

	//////////////////////////////
	// shifter
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			div_cnt    <= '0;
			bit_cnt    <= 3'd0;
			o_spi_dclk <= 1'b0;
			tx_shift   <= 8'h00;
			rx_shift   <= 8'h00;
		end else if (!busy) begin
			if (i_wr_req) begin
				busy     <= 1'b1;
				div_cnt  <= '0;
				bit_cnt  <= 3'd0;
				tx_shift <= i_tx_byte; // msb is on mosi before the first rising edge
			end
		end else if (half_end) begin
			div_cnt    <= '0;
			o_spi_dclk <= ~o_spi_dclk;
			if (!o_spi_dclk) begin
				rx_shift <= {rx_shift[6:0], i_spi_miso}; // rising edge samples miso
			end else begin
				// falling edge moves the next bit onto mosi
				tx_shift <= {tx_shift[6:0], 1'b0};
				bit_cnt  <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7)
					busy <= 1'b0;
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/w5500_tx_buf.sv
`timescale 1ns/1ps
`default_nettype none

module w5500_tx_buf (
	input  wire                           clk,
	input  wire                           i_wr_en,
	input  wire [w5500_pkg::BUF_AW-1:0]   i_wr_addr,
	input  wire [7:0]                     i_wr_data,
	input  wire [w5500_pkg::BUF_AW-1:0]   i_rd_addr,
	output logic [7:0]                    o_rd_data
);
	import w5500_pkg::*;

	localparam int unsigned DEPTH = 1 << BUF_AW;

	// one socket TX buffer worth of payload
	logic [7:0] mem [0:DEPTH-1];

	//////////////////////////////
	// host write port
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	//////////////////////////////
	// sequencer read port
	//////////////////////////////
	// registered, so data follows the address by one cycle
	always_ff @(posedge clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

//--- hw/w5500_pkg.sv
`default_nettype none

package w5500_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	localparam int unsigned CMD_W     = 8;
	localparam int unsigned HDR_BYTES = 3; // two address bytes and the control byte
	localparam int unsigned BUF_AW    = 11;
	localparam int unsigned CLK_DIV_W = 16;

	//////////////////////////////
	// command codes
	//////////////////////////////
	localparam logic [CMD_W-1:0] CMD_GATEWAY        = 8'h01;
	localparam logic [CMD_W-1:0] CMD_NETMASK        = 8'h02;
	localparam logic [CMD_W-1:0] CMD_SMAC           = 8'h03;
	localparam logic [CMD_W-1:0] CMD_SIP            = 8'h04;
	localparam logic [CMD_W-1:0] CMD_PHY_STATE      = 8'h05;
	localparam logic [CMD_W-1:0] CMD_RTR            = 8'h06;
	localparam logic [CMD_W-1:0] CMD_RCR            = 8'h07;
	localparam logic [CMD_W-1:0] CMD_SOCK_MODE      = 8'h10;
	localparam logic [CMD_W-1:0] CMD_SOCK_CMD       = 8'h11;
	localparam logic [CMD_W-1:0] CMD_SOCK_INT       = 8'h12;
	localparam logic [CMD_W-1:0] CMD_SOCK_STATE     = 8'h13;
	localparam logic [CMD_W-1:0] CMD_SOCK_SPORT     = 8'h14;
	localparam logic [CMD_W-1:0] CMD_SOCK_RBUF_SIZE = 8'h15;
	localparam logic [CMD_W-1:0] CMD_SOCK_TBUF_SIZE = 8'h16;
	localparam logic [CMD_W-1:0] CMD_SOCK_TX_FSIZE  = 8'h17;
	localparam logic [CMD_W-1:0] CMD_SOCK_TX_WPOINT = 8'h18;
	localparam logic [CMD_W-1:0] CMD_SOCK_RX_SIZE   = 8'h19;
	localparam logic [CMD_W-1:0] CMD_SOCK_RX_RPOINT = 8'h1A;
	localparam logic [CMD_W-1:0] CMD_SOCK_KEEPALIVE = 8'h1B;
	localparam logic [CMD_W-1:0] CMD_SOCK_BUF       = 8'h20;

	//////////////////////////////
	// register offsets
	//////////////////////////////
	// common block
	localparam logic [15:0] REG_GAR0    = 16'h0001;
	localparam logic [15:0] REG_SUBR0   = 16'h0005;
	localparam logic [15:0] REG_SHAR0   = 16'h0009;
	localparam logic [15:0] REG_SIPR0   = 16'h000F;
	localparam logic [15:0] REG_RTR0    = 16'h0019;
	localparam logic [15:0] REG_RCR     = 16'h001B;
	localparam logic [15:0] REG_PHYCFGR = 16'h002E;

	// socket register block, same offsets for every socket
	localparam logic [15:0] SN_MR         = 16'h0000;
	localparam logic [15:0] SN_CR         = 16'h0001;
	localparam logic [15:0] SN_IR         = 16'h0002;
	localparam logic [15:0] SN_SR         = 16'h0003;
	localparam logic [15:0] SN_PORT0      = 16'h0004;
	localparam logic [15:0] SN_RXBUF_SIZE = 16'h001E;
	localparam logic [15:0] SN_TXBUF_SIZE = 16'h001F;
	localparam logic [15:0] SN_TX_FSR0    = 16'h0020; // read only
	localparam logic [15:0] SN_TX_WR0     = 16'h0024;
	localparam logic [15:0] SN_RX_RSR0    = 16'h0026; // read only
	localparam logic [15:0] SN_RX_RD0     = 16'h0028;
	localparam logic [15:0] SN_KPALVTR    = 16'h002F;

	//////////////////////////////
	// control byte fields
	//////////////////////////////
	// the control byte is {socket[2:0], bsb[1:0], rw, om[1:0]}
	localparam logic [1:0] BSB_COMMON   = 2'b00;
	localparam logic [1:0] BSB_SOCK_REG = 2'b01;
	localparam logic [1:0] BSB_SOCK_TX  = 2'b10;
	localparam logic [1:0] BSB_SOCK_RX  = 2'b11;

	localparam logic RW_READ  = 1'b0;
	localparam logic RW_WRITE = 1'b1;

endpackage

`default_nettype wire
